// File: common/rob_pkg.sv
// Reorder buffer shared types
package rob_pkg;

    // Widths that carry a meaning in the datapath
    typedef logic [31:0] data_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  rat_idx_t;

    // Buffer tag, wide enough for a depth of up to 16 slots
    typedef logic [3:0]  rob_idx_t;

    // Op class as it arrives from dispatch
    typedef enum logic [2:0] {
        OPC_ALU    = 3'd0,
        OPC_BRANCH = 3'd1,
        OPC_JL     = 3'd2,
        OPC_LD     = 3'd3,
        OPC_ST     = 3'd4
    } opcode_t;

    // One-hot op kind held by every entry
    localparam int OP_IS_WIDTH   = 5;
    localparam int OP_IS_ALU_IDX = 0;
    localparam int OP_IS_BR_IDX  = 1;
    localparam int OP_IS_JL_IDX  = 2;
    localparam int OP_IS_LD_IDX  = 3;
    localparam int OP_IS_ST_IDX  = 4;

    typedef logic [OP_IS_WIDTH-1:0] op_is_t;

    // Raw dispatch as seen at the top level ports
    typedef struct packed {
        opcode_t  opcode;
        addr_t    pc;
        rat_idx_t rdst;
        data_t    rdst_data;
    } dispatch_t;

    // Decoded dispatch written into the tail slot
    typedef struct packed {
        op_is_t   op_is;
        addr_t    pc;
        rat_idx_t rdst;
        data_t    rdst_data;
    } entry_init_t;

    // One port of the common data bus
    typedef struct packed {
        logic     en;
        logic     redirect;
        data_t    data;
        rob_idx_t tag;
    } cdb_t;

    // Contents of an entry, and of the head entry as it retires
    typedef struct packed {
        logic     redirect;
        data_t    data;
        rat_idx_t rdst;
        op_is_t   op_is;
        addr_t    pc;
    } retire_t;

endpackage

// File: rtl/rob_dispatch_decode.sv
// Dispatch opcode decode
module rob_dispatch_decode (
    input  rob_pkg::dispatch_t   i_dispatch,
    output rob_pkg::entry_init_t o_entry_init
);
    import rob_pkg::*;

    // One-hot op kind built from the dispatched class
    op_is_t op_is;

    // Each opcode class lights exactly one bit of the op kind
    // An unknown class leaves the vector empty so the check below catches it
    always_comb begin
        op_is = '0;

        case (i_dispatch.opcode)
            OPC_ALU: begin
                op_is[OP_IS_ALU_IDX] = 1'b1;
            end
            OPC_BRANCH: begin
                op_is[OP_IS_BR_IDX] = 1'b1;
            end
            OPC_JL: begin
                op_is[OP_IS_JL_IDX] = 1'b1;
            end
            OPC_LD: begin
                op_is[OP_IS_LD_IDX] = 1'b1;
            end
            OPC_ST: begin
                op_is[OP_IS_ST_IDX] = 1'b1;
            end
            default: begin
                op_is = '0;
            end
        endcase
    end

    // The remaining fields pass to the queue unchanged
    // The pc is the instruction address, later replaced by the target on a jump-and-link
    always_comb begin
        o_entry_init.op_is     = op_is;
        o_entry_init.pc        = i_dispatch.pc;
        o_entry_init.rdst      = i_dispatch.rdst;
        o_entry_init.rdst_data = i_dispatch.rdst_data;
    end

    // The queue and the entries rely on exactly one op kind bit being set
    // Without it a load or store would never wait for its LSU acknowledge
    always_comb begin
        if (!$isunknown(i_dispatch.opcode)) begin
            assert ($onehot(o_entry_init.op_is))
                else $error("decode produced an op kind that is not one-hot");
        end
    end

endmodule

// File: rob/rob_entry.sv
// Reorder buffer slot
module rob_entry #(
    parameter int OPTN_CDB_DEPTH = 2
) (
    input  logic                 clk,
    input  logic                 i_reset,

    // Flush from a redirecting retirement
    input  logic                 i_flush,

    // Fixed tag of this slot
    input  rob_pkg::rob_idx_t    i_rob_tag,

    // Common data bus, one element per port
    input  rob_pkg::cdb_t        i_cdb [OPTN_CDB_DEPTH],

    // Dispatch into this slot
    input  logic                 i_dispatch_en,
    input  rob_pkg::entry_init_t i_entry_init,

    // Retire and LSU acknowledges, already gated to the head slot
    input  logic                 i_retire_en,
    input  logic                 i_lsu_retire_lq_ack,
    input  logic                 i_lsu_retire_sq_ack,
    input  logic                 i_lsu_retire_misspeculated,

    output logic                 o_retirable,
    output logic                 o_lsu_pending,
    output rob_pkg::retire_t     o_entry
);
    import rob_pkg::*;

    typedef enum logic [1:0] {
        INVALID     = 2'b00,
        PENDING     = 2'b01,
        LSU_PENDING = 2'b10,
        RETIRABLE   = 2'b11
    } entry_state_t;

    entry_state_t state_r;
    entry_state_t state_next;

    // Payload of the slot, laid out the same way it leaves at retirement
    retire_t entry_r;
    retire_t entry_next;

    // Per-port tag match, only while the op waits for its result
    logic [OPTN_CDB_DEPTH-1:0] cdb_match;
    logic                      cdb_hit;

    // A load or store leaves PENDING for LSU_PENDING instead of RETIRABLE
    logic is_lsu_op;
    logic lq_done;
    logic sq_done;

    always_comb begin
        for (int i = 0; i < OPTN_CDB_DEPTH; i++) begin
            cdb_match[i] = (state_r == PENDING) && i_cdb[i].en && (i_cdb[i].tag == i_rob_tag);
        end
    end

    assign cdb_hit   = |cdb_match;
    assign is_lsu_op = entry_r.op_is[OP_IS_LD_IDX] | entry_r.op_is[OP_IS_ST_IDX];

    // The load queue ack only counts for a load, and the store queue ack for a store
    assign lq_done = (state_r == LSU_PENDING) && entry_r.op_is[OP_IS_LD_IDX] && i_lsu_retire_lq_ack;
    assign sq_done = (state_r == LSU_PENDING) && entry_r.op_is[OP_IS_ST_IDX] && i_lsu_retire_sq_ack;

    // Payload update, lowest priority first
    always_comb begin
        entry_next = entry_r;

        // The load queue reports a misspeculated load through the redirect bit
        if (lq_done) begin
            entry_next.redirect = i_lsu_retire_misspeculated;
        end

        // Bus results land in data, or in pc when the op is a jump-and-link
        for (int i = 0; i < OPTN_CDB_DEPTH; i++) begin
            if (cdb_match[i]) begin
                entry_next.redirect = i_cdb[i].redirect;
                if (entry_r.op_is[OP_IS_JL_IDX]) begin
                    entry_next.pc = addr_t'(i_cdb[i].data);
                end else begin
                    entry_next.data = i_cdb[i].data;
                end
            end
        end

        // A new op replaces everything and starts with redirect clear
        if (i_dispatch_en) begin
            entry_next.redirect = 1'b0;
            entry_next.data     = i_entry_init.rdst_data;
            entry_next.rdst     = i_entry_init.rdst;
            entry_next.op_is    = i_entry_init.op_is;
            entry_next.pc       = i_entry_init.pc;
        end
    end

    always_ff @(posedge clk) begin
        entry_r <= entry_next;
    end

    // Slot life cycle
    always_comb begin
        state_next = state_r;

        case (state_r)
            INVALID: begin
                if (i_dispatch_en) state_next = PENDING;
            end
            PENDING: begin
                if (cdb_hit) state_next = is_lsu_op ? LSU_PENDING : RETIRABLE;
            end
            LSU_PENDING: begin
                if (lq_done || sq_done) state_next = RETIRABLE;
            end
            RETIRABLE: begin
                if (i_retire_en) state_next = INVALID;
            end
            default: begin
                state_next = INVALID;
            end
        endcase

        // A flush empties the slot whatever it was doing
        if (i_flush) state_next = INVALID;
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state_r <= INVALID;
        end else begin
            state_r <= state_next;
        end
    end

    assign o_retirable   = (state_r == RETIRABLE);
    assign o_lsu_pending = (state_r == LSU_PENDING);
    assign o_entry       = entry_r;

    // The queue only writes the tail slot, which must have been retired or flushed
    a_dispatch_to_free: assert property (@(posedge clk) disable iff (i_reset)
        i_dispatch_en |-> (state_r == INVALID));

    // The queue only retires the head slot once it has completed
    a_retire_completed: assert property (@(posedge clk) disable iff (i_reset)
        i_retire_en |-> (state_r == RETIRABLE));

endmodule

// File: rob/rob_queue.sv
// Reorder buffer queue
module rob_queue #(
    parameter int OPTN_ROB_DEPTH = 8,
    parameter int OPTN_CDB_DEPTH = 2
) (
    input  logic                 clk,
    input  logic                 i_reset,

    input  logic                 i_dispatch_en,
    input  rob_pkg::entry_init_t i_entry_init,

    input  rob_pkg::cdb_t        i_cdb [OPTN_CDB_DEPTH],

    input  logic                 i_lsu_retire_lq_ack,
    input  logic                 i_lsu_retire_sq_ack,
    input  logic                 i_lsu_retire_misspeculated,

    output rob_pkg::rob_idx_t    o_dispatch_tag,
    output logic                 o_rob_full,
    output logic                 o_lsu_retire_req,
    output logic                 o_retire_en,
    output rob_pkg::retire_t     o_retire
);
    import rob_pkg::*;

    localparam int IDX_W = $clog2(OPTN_ROB_DEPTH);

    // Pointers wrap on their own since the depth is a power of two
    logic [IDX_W-1:0] head_r;
    logic [IDX_W-1:0] tail_r;
    logic [IDX_W:0]   count_r;

    // Per-slot status and contents
    logic [OPTN_ROB_DEPTH-1:0] retirable;
    logic [OPTN_ROB_DEPTH-1:0] lsu_pending;
    retire_t                   entries [OPTN_ROB_DEPTH];

    // Per-slot steering of dispatch, retire and the LSU acknowledges
    logic [OPTN_ROB_DEPTH-1:0] dispatch_sel;
    logic [OPTN_ROB_DEPTH-1:0] retire_sel;
    logic [OPTN_ROB_DEPTH-1:0] lq_ack_sel;
    logic [OPTN_ROB_DEPTH-1:0] sq_ack_sel;

    logic dispatch_fire;
    logic flush;

    assign o_rob_full     = (count_r == (IDX_W+1)'(OPTN_ROB_DEPTH));
    assign o_dispatch_tag = rob_idx_t'(tail_r);

    // The head slot decides retirement and the LSU request
    assign o_retire_en      = retirable[head_r];
    assign o_retire         = entries[head_r];
    assign o_lsu_retire_req = lsu_pending[head_r];

    // A redirecting op retires normally and empties the buffer at the same edge
    assign flush = o_retire_en & o_retire.redirect;

    // Dispatch is dropped when full, or when it is younger than a redirect
    assign dispatch_fire = i_dispatch_en & ~o_rob_full & ~flush;

    always_comb begin
        for (int i = 0; i < OPTN_ROB_DEPTH; i++) begin
            dispatch_sel[i] = dispatch_fire && (tail_r == IDX_W'(i));
            retire_sel[i]   = o_retire_en && (head_r == IDX_W'(i));
            // LSU acknowledges always refer to the oldest op
            lq_ack_sel[i]   = i_lsu_retire_lq_ack && (head_r == IDX_W'(i));
            sq_ack_sel[i]   = i_lsu_retire_sq_ack && (head_r == IDX_W'(i));
        end
    end

    for (genvar g = 0; g < OPTN_ROB_DEPTH; g++) begin : g_entry
        rob_entry #(
            .OPTN_CDB_DEPTH(OPTN_CDB_DEPTH)
        ) u_entry (
            .clk                        (clk),
            .i_reset                    (i_reset),
            .i_flush                    (flush),
            .i_rob_tag                  (rob_idx_t'(g)),
            .i_cdb                      (i_cdb),
            .i_dispatch_en              (dispatch_sel[g]),
            .i_entry_init               (i_entry_init),
            .i_retire_en                (retire_sel[g]),
            .i_lsu_retire_lq_ack        (lq_ack_sel[g]),
            .i_lsu_retire_sq_ack        (sq_ack_sel[g]),
            .i_lsu_retire_misspeculated (i_lsu_retire_misspeculated),
            .o_retirable                (retirable[g]),
            .o_lsu_pending              (lsu_pending[g]),
            .o_entry                    (entries[g])
        );
    end

    // Head, tail and count move together, and a flush returns them all to zero
    always_ff @(posedge clk) begin
        if (i_reset || flush) begin
            head_r  <= '0;
            tail_r  <= '0;
            count_r <= '0;
        end else begin
            if (dispatch_fire) tail_r <= tail_r + 1'b1;
            if (o_retire_en) head_r <= head_r + 1'b1;

            case ({dispatch_fire, o_retire_en})
                2'b10:   count_r <= count_r + 1'b1;
                2'b01:   count_r <= count_r - 1'b1;
                default: count_r <= count_r;
            endcase
        end
    end

    // Dropping dispatches while full keeps the occupancy bounded
    a_count_bound: assert property (@(posedge clk) disable iff (i_reset)
        count_r <= (IDX_W+1)'(OPTN_ROB_DEPTH));

    // A retiring head must be an op that the count still holds
    a_retire_head: assert property (@(posedge clk) disable iff (i_reset)
        o_retire_en |-> (count_r != '0));

endmodule

// File: rtl/rob_top.sv
// Reorder buffer top level
module rob_top #(
    parameter int OPTN_ROB_DEPTH = 8,
    parameter int OPTN_CDB_DEPTH = 2
) (
    input  logic               clk,
    input  logic               i_reset,

    // Dispatch in program order
    input  logic               i_dispatch_en,
    input  rob_pkg::dispatch_t i_dispatch,

    // Common data bus from the execution units
    input  rob_pkg::cdb_t      i_cdb [OPTN_CDB_DEPTH],

    // Acknowledges from the load and store queues
    input  logic               i_lsu_retire_lq_ack,
    input  logic               i_lsu_retire_sq_ack,
    input  logic               i_lsu_retire_misspeculated,

    output rob_pkg::rob_idx_t  o_dispatch_tag,
    output logic               o_rob_full,
    output logic               o_lsu_retire_req,
    output logic               o_retire_en,
    output rob_pkg::retire_t   o_retire
);
    import rob_pkg::*;

    // Decoded dispatch on its way to the tail slot
    entry_init_t entry_init;

    rob_dispatch_decode u_decode (
        .i_dispatch   (i_dispatch),
        .o_entry_init (entry_init)
    );

    // The queue owns the slots, the pointers and retirement
    rob_queue #(
        .OPTN_ROB_DEPTH(OPTN_ROB_DEPTH),
        .OPTN_CDB_DEPTH(OPTN_CDB_DEPTH)
    ) u_queue (
        .clk                        (clk),
        .i_reset                    (i_reset),
        .i_dispatch_en              (i_dispatch_en),
        .i_entry_init               (entry_init),
        .i_cdb                      (i_cdb),
        .i_lsu_retire_lq_ack        (i_lsu_retire_lq_ack),
        .i_lsu_retire_sq_ack        (i_lsu_retire_sq_ack),
        .i_lsu_retire_misspeculated (i_lsu_retire_misspeculated),
        .o_dispatch_tag             (o_dispatch_tag),
        .o_rob_full                 (o_rob_full),
        .o_lsu_retire_req           (o_lsu_retire_req),
        .o_retire_en                (o_retire_en),
        .o_retire                   (o_retire)
    );

endmodule

// File: test/rob_ref.svh
// Reorder buffer reference model
`ifndef ROB_REF_SVH
`define ROB_REF_SVH

// What each tag was dispatched with and what completed it
dispatch_t sent_op      [16];
data_t     result_data  [16];
logic      result_redir [16];
logic      load_misspec [16];

// Tags in program order that still have to retire
rob_idx_t retire_order [$];

// Expected retirement of one op from its dispatch and its completion
function automatic retire_t expected_retire(input dispatch_t d, input data_t bus_data,
                                            input logic bus_redir, input logic misspec);
    retire_t r;
    r.op_is = '0;
    case (d.opcode)
        OPC_ALU:    r.op_is[OP_IS_ALU_IDX] = 1'b1;
        OPC_BRANCH: r.op_is[OP_IS_BR_IDX]  = 1'b1;
        OPC_JL:     r.op_is[OP_IS_JL_IDX]  = 1'b1;
        OPC_LD:     r.op_is[OP_IS_LD_IDX]  = 1'b1;
        OPC_ST:     r.op_is[OP_IS_ST_IDX]  = 1'b1;
        default:    r.op_is = '0;
    endcase
    r.rdst = d.rdst;
    // A jump-and-link keeps its link value and takes the target as pc
    if (d.opcode == OPC_JL) begin
        r.data = d.rdst_data;
        r.pc   = addr_t'(bus_data);
    end else begin
        r.data = bus_data;
        r.pc   = d.pc;
    end
    // The load queue has the last word on the redirect of a load
    r.redirect = (d.opcode == OPC_LD) ? misspec : bus_redir;
    return r;
endfunction

function automatic void record_dispatch(input rob_idx_t tag, input dispatch_t d);
    sent_op[tag]      = d;
    result_data[tag]  = '0;
    result_redir[tag] = 1'b0;
    load_misspec[tag] = 1'b0;
    retire_order.push_back(tag);
endfunction

function automatic void record_result(input rob_idx_t tag, input data_t d, input logic redir);
    result_data[tag]  = d;
    result_redir[tag] = redir;
endfunction

`endif

// File: test/rob_tb.sv
// Reorder buffer testbench
module rob_tb;
    import rob_pkg::*;

    localparam int ROB_DEPTH  = 8;
    localparam int CDB_DEPTH  = 2;
    localparam int WAIT_LIMIT = 50;

    logic      clk;
    logic      reset;
    logic      dispatch_en;
    dispatch_t dispatch;
    cdb_t      cdb [CDB_DEPTH];
    logic      lq_ack;
    logic      sq_ack;
    logic      misspec;
    rob_idx_t  dispatch_tag;
    logic      rob_full;
    logic      lsu_req;
    logic      retire_en;
    retire_t   retire;

    int errors = 0;
    int checks = 0;
    int retired = 0;
    // Running total of retirements the stimulus has asked for so far
    int retire_target = 0;

    `include "rob_ref.svh"

    rob_top #(
        .OPTN_ROB_DEPTH(ROB_DEPTH),
        .OPTN_CDB_DEPTH(CDB_DEPTH)
    ) DUT (
        .clk                        (clk),
        .i_reset                    (reset),
        .i_dispatch_en              (dispatch_en),
        .i_dispatch                 (dispatch),
        .i_cdb                      (cdb),
        .i_lsu_retire_lq_ack        (lq_ack),
        .i_lsu_retire_sq_ack        (sq_ack),
        .i_lsu_retire_misspeculated (misspec),
        .o_dispatch_tag             (dispatch_tag),
        .o_rob_full                 (rob_full),
        .o_lsu_retire_req           (lsu_req),
        .o_retire_en                (retire_en),
        .o_retire                   (retire)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            $display("Mismatch at time %0t: %s is %h, expected %h", $time, what, actual, expected);
            errors++;
        end
    endtask

    task automatic finish_run();
        $display("Checks: %0d, retired: %0d, errors: %0d", checks, retired, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout at time %0t while waiting for %s", $time, what);
        errors++;
        finish_run();
    endtask

    // Moves to the next falling edge and drops every one-cycle input
    task automatic step();
        @(negedge clk);
        dispatch_en = 1'b0;
        for (int p = 0; p < CDB_DEPTH; p++) begin
            cdb[p] = '0;
        end
        lq_ack  = 1'b0;
        sq_ack  = 1'b0;
        misspec = 1'b0;
    endtask

    // The tag is read in the same cycle, before the tail moves
    task automatic dispatch_op(input opcode_t opc, input addr_t pc, input rat_idx_t rdst,
                               input data_t rdst_data, output rob_idx_t tag);
        dispatch_t d;
        d = '{opcode: opc, pc: pc, rdst: rdst, rdst_data: rdst_data};
        check_value(rob_full, 1'b0, "full flag before a dispatch");
        dispatch_en = 1'b1;
        dispatch    = d;
        tag         = dispatch_tag;
        record_dispatch(tag, d);
        step();
    endtask

    // Puts one result on a bus port without ending the cycle
    task automatic drive_result(input int port, input rob_idx_t tag, input data_t d,
                                input logic redir);
        cdb[port] = '{en: 1'b1, redirect: redir, data: d, tag: tag};
        record_result(tag, d, redir);
    endtask

    // The count is read on the rising edge, away from the comparing process
    task automatic wait_retired(input int n);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) stop_on_timeout("retirements");
        end while (retired < n);
        @(negedge clk);
    endtask

    task automatic wait_lsu_req();
        int cycles;
        cycles = 0;
        while (!lsu_req) begin
            step();
            cycles++;
            if (cycles > WAIT_LIMIT) stop_on_timeout("the LSU retire request");
        end
    endtask

    // After a redirect nothing else retires and the tail restarts at zero
    task automatic check_flushed();
        rob_idx_t tag;
        repeat (3) begin
            check_value(retire_en, 1'b0, "retire enable after a redirect");
            step();
        end
        dispatch_op(OPC_ALU, 32'h0000_6000, 5'd9, 32'h0, tag);
        check_value(tag, 0, "tag after a redirect");
        drive_result(0, tag, $urandom, 1'b0);
        step();
        retire_target++;
        wait_retired(retire_target);
    endtask

    // Every retirement is checked against the oldest expected op
    always @(negedge clk) begin
        rob_idx_t tag;
        retire_t  want;
        if (!reset && retire_en) begin
            if (retire_order.size() == 0) begin
                $display("Unexpected retirement at time %0t with no op left to retire", $time);
                errors++;
            end else begin
                tag  = retire_order.pop_front();
                want = expected_retire(sent_op[tag], result_data[tag], result_redir[tag],
                                       load_misspec[tag]);
                check_value(retire.redirect, want.redirect, "retire redirect");
                check_value(retire.data, want.data, "retire data");
                check_value(retire.rdst, want.rdst, "retire rdst");
                check_value(retire.op_is, want.op_is, "retire op kind");
                check_value(retire.pc, want.pc, "retire pc");
                retired++;
                // Younger ops are flushed and will never show up
                if (want.redirect) retire_order.delete();
            end
        end
    end

    initial begin
        rob_idx_t tags [ROB_DEPTH];
        rob_idx_t young [2];
        rob_idx_t tag;
        rob_idx_t swap;
        int       i;
        int       j;

        void'($urandom(32'ha11f));
        reset       = 1'b1;
        dispatch_en = 1'b0;
        dispatch    = '0;
        lq_ack      = 1'b0;
        sq_ack      = 1'b0;
        misspec     = 1'b0;
        for (int p = 0; p < CDB_DEPTH; p++) begin
            cdb[p] = '0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_value(retire_en, 1'b0, "retire enable after reset");
        check_value(lsu_req, 1'b0, "LSU request after reset");
        check_value(rob_full, 1'b0, "full flag after reset");

        // ALU ops complete in a shuffled order, the first two on both ports at once
        for (i = 0; i < 6; i++) begin
            dispatch_op(OPC_ALU, 32'h1000 + 4 * i, rat_idx_t'(i + 1), $urandom, tags[i]);
        end
        for (i = 5; i > 0; i--) begin
            j       = $urandom % (i + 1);
            swap    = tags[i];
            tags[i] = tags[j];
            tags[j] = swap;
        end
        i = 0;
        while (i < 6) begin
            if (i == 0 || (i < 5 && ($urandom % 2) == 1)) begin
                drive_result(0, tags[i], $urandom, 1'b0);
                drive_result(1, tags[i + 1], $urandom, 1'b0);
                i += 2;
            end else begin
                drive_result($urandom % 2, tags[i], $urandom, 1'b0);
                i++;
            end
            step();
        end
        retire_target += 6;
        wait_retired(retire_target);

        // Jump-and-link takes the target into pc
        dispatch_op(OPC_JL, 32'h2000, 5'd31, 32'h2004, tag);
        drive_result(1, tag, $urandom & 32'hffff_fffc, 1'b0);
        step();
        retire_target++;
        wait_retired(retire_target);

        // A store holds at the head until the store queue acknowledges
        dispatch_op(OPC_ST, 32'h3000, 5'd0, $urandom, tag);
        drive_result(0, tag, $urandom, 1'b0);
        step();
        wait_lsu_req();
        repeat (3) begin
            check_value(retire_en, 1'b0, "retire enable while the store waits");
            check_value(lsu_req, 1'b1, "LSU request while the store waits");
            step();
        end
        sq_ack = 1'b1;
        step();
        retire_target++;
        wait_retired(retire_target);

        // A misspeculated load redirects and drops the completed younger ops
        dispatch_op(OPC_LD, 32'h4000, 5'd7, 32'h0, tag);
        dispatch_op(OPC_ALU, 32'h4004, 5'd8, 32'h0, young[0]);
        dispatch_op(OPC_ALU, 32'h4008, 5'd9, 32'h0, young[1]);
        drive_result(0, young[0], $urandom, 1'b0);
        drive_result(1, young[1], $urandom, 1'b0);
        step();
        drive_result(0, tag, $urandom, 1'b0);
        step();
        wait_lsu_req();
        lq_ack  = 1'b1;
        misspec = 1'b1;
        load_misspec[tag] = 1'b1;
        step();
        retire_target++;
        wait_retired(retire_target);
        check_flushed();

        // A branch resolved with a redirect on the bus flushes the same way
        dispatch_op(OPC_BRANCH, 32'h5000, 5'd0, 32'h0, tag);
        dispatch_op(OPC_ALU, 32'h5004, 5'd10, 32'h0, young[0]);
        dispatch_op(OPC_ALU, 32'h5008, 5'd11, 32'h0, young[1]);
        drive_result(0, young[1], $urandom, 1'b0);
        drive_result(1, young[0], $urandom, 1'b0);
        step();
        drive_result(1, tag, $urandom, 1'b1);
        step();
        retire_target++;
        wait_retired(retire_target);
        check_flushed();

        // Fill every slot, then free one by retiring the head
        for (i = 0; i < ROB_DEPTH; i++) begin
            dispatch_op(OPC_ALU, 32'h7000 + 4 * i, rat_idx_t'(i), $urandom, tags[i]);
        end
        check_value(rob_full, 1'b1, "full flag with every slot used");
        drive_result(0, tags[0], $urandom, 1'b0);
        step();
        retire_target++;
        wait_retired(retire_target);
        check_value(rob_full, 1'b0, "full flag after one retirement");
        for (i = 1; i < ROB_DEPTH; i++) begin
            drive_result(i % 2, tags[i], $urandom, 1'b0);
            step();
        end
        retire_target += ROB_DEPTH - 1;
        wait_retired(retire_target);

        check_value(retire_order.size(), 0, "ops still waiting to retire");
        finish_run();
    end

endmodule

// File: src.f
+incdir+test
common/rob_pkg.sv
rtl/rob_dispatch_decode.sv
rob/rob_entry.sv
rob/rob_queue.sv
rtl/rob_top.sv
test/rob_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the reorder buffer testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module rob_tb -f src.f -o rob_sim

sim_out=$(./obj_dir/rob_sim)
echo "$sim_out"

if echo "$sim_out" | grep -qF -- '** PASS **'; then
    exit 0
fi
echo "Simulation did not pass"
exit 1
